//--- design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic          valid,
    input  logic          br_eq,
    input  logic          br_ne,
    input  logic          jump_imm,
    input  logic          jump_reg,
    input  logic [15:0]   imm,
    input  logic [25:0]   jidx,
    input  id_pkg::word_t fs_pc,
    input  id_pkg::word_t rs_value,
    input  id_pkg::word_t rt_value,
    output logic          br_taken,
    output id_pkg::word_t br_target
);
    import id_pkg::*;

    logic  rs_eq_rt;
    logic  is_branch;
    word_t branch_offset;

    assign rs_eq_rt  = (rs_value == rt_value);
    assign is_branch = br_eq | br_ne;

    // sign-extended word offset
    assign branch_offset = {{14{imm[15]}}, imm, 2'b00};

    assign br_taken = valid && ((br_eq && rs_eq_rt) ||
                                (br_ne && !rs_eq_rt) ||
                                jump_imm ||
                                jump_reg);

    always_comb begin
        if (is_branch) begin
            br_target = fs_pc + branch_offset;
        end else if (jump_reg) begin
            br_target = rs_value;
        end else begin
            // j, jal stay in the current 256 MB region
            br_target = {fs_pc[31:28], jidx, 2'b00};
        end
    end

endmodule

//--- design/id_pkg.sv
package id_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 32;
    localparam int ALU_OP_W   = 12;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;

    // one-hot alu operation bits
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of special, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam logic [4:0] REG_LINK = 5'd31;

    // rs and rt
    localparam int NUM_SRC = 2;

endpackage

//--- design/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              es_allowin,
    output logic              ds_allowin,
    input  logic              fs_to_ds_valid,
    input  id_pkg::word_t     fs_inst,
    input  id_pkg::word_t     fs_pc,
    input  id_pkg::word_t     fs_inst_pc,
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_waddr,
    input  id_pkg::word_t     wb_wdata,
    input  id_pkg::reg_addr_t exe_dest,
    input  id_pkg::reg_addr_t mem_dest,
    input  id_pkg::reg_addr_t wb_dest,
    input  id_pkg::word_t     exe_data,
    input  id_pkg::word_t     mem_data,
    input  id_pkg::word_t     wb_data,
    input  logic              es_load_op,
    input  logic              ms_load_op,
    input  logic              data_ok,
    output logic              ds_to_es_valid,
    output id_pkg::alu_op_t   es_alu_op,
    output logic              es_src1_is_sa,
    output logic              es_src1_is_pc,
    output logic              es_src2_is_imm,
    output logic              es_src2_is_imm_zero,
    output logic              es_src2_is_8,
    output logic              es_load_op_out,
    output logic              es_mem_we,
    output logic              es_gr_we,
    output id_pkg::reg_addr_t es_dest,
    output logic [15:0]       es_imm,
    output id_pkg::word_t     es_rs_value,
    output id_pkg::word_t     es_rt_value,
    output id_pkg::word_t     es_pc,
    output logic              br_taken,
    output logic              br_stall,
    output id_pkg::word_t     br_target
);
    import id_pkg::*;

    logic  ds_valid;
    logic  ds_ready_go;
    logic  load_stall;
    word_t ds_inst;
    word_t ds_pc;
    word_t ds_next_pc;

    reg_addr_t            rs;
    reg_addr_t            rt;
    logic [25:0]          jidx;
    logic                 uses_rs;
    logic                 uses_rt;
    logic                 br_eq;
    logic                 br_ne;
    logic                 jump_imm;
    logic                 jump_reg;
    reg_addr_t [NUM_SRC-1:0] src_addr;
    logic      [NUM_SRC-1:0] src_used;
    word_t     [NUM_SRC-1:0] rf_rdata;
    word_t     [NUM_SRC-1:0] src_value;
    logic      [NUM_SRC-1:0] src_stall;

    assign load_stall     = |src_stall;
    assign ds_ready_go    = ds_valid && !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid   <= 1'b0;
            ds_inst    <= '0;
            ds_pc      <= '0;
            ds_next_pc <= '0;
        end else begin
            if (ds_allowin) begin
                ds_valid <= fs_to_ds_valid;
            end
            if (fs_to_ds_valid && ds_allowin) begin
                ds_inst    <= fs_inst;
                ds_pc      <= fs_inst_pc;
                ds_next_pc <= fs_pc;
            end
        end
    end

    assign es_pc = ds_pc;

    inst_decoder u_dec (
        .inst             (ds_inst),
        .rs               (rs),
        .rt               (rt),
        .rd               (),
        .imm              (es_imm),
        .jidx             (jidx),
        .alu_op           (es_alu_op),
        .src1_is_sa       (es_src1_is_sa),
        .src1_is_pc       (es_src1_is_pc),
        .src2_is_imm      (es_src2_is_imm),
        .src2_is_imm_zero (es_src2_is_imm_zero),
        .src2_is_8        (es_src2_is_8),
        .load_op          (es_load_op_out),
        .mem_we           (es_mem_we),
        .gr_we            (es_gr_we),
        .dest             (es_dest),
        .uses_rs          (uses_rs),
        .uses_rt          (uses_rt),
        .br_eq            (br_eq),
        .br_ne            (br_ne),
        .jump_imm         (jump_imm),
        .jump_reg         (jump_reg)
    );

    // index 0 is rs, index 1 is rt
    assign src_addr = {rt, rs};
    assign src_used = {uses_rt, uses_rs};

    regfile u_rf (
        .clk   (clk),
        .raddr (src_addr),
        .rdata (rf_rdata),
        .we    (wb_we),
        .waddr (wb_waddr),
        .wdata (wb_wdata)
    );

    for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
        operand_unit u_opnd (
            .src        (src_addr[i]),
            .uses_src   (src_used[i]),
            .rf_data    (rf_rdata[i]),
            .exe_dest   (exe_dest),
            .mem_dest   (mem_dest),
            .wb_dest    (wb_dest),
            .exe_data   (exe_data),
            .mem_data   (mem_data),
            .wb_data    (wb_data),
            .es_load_op (es_load_op),
            .ms_load_op (ms_load_op),
            .data_ok    (data_ok),
            .value      (src_value[i]),
            .stall      (src_stall[i])
        );
    end

    assign es_rs_value = src_value[0];
    assign es_rt_value = src_value[1];

    branch_unit u_br (
        .valid     (ds_valid),
        .br_eq     (br_eq),
        .br_ne     (br_ne),
        .jump_imm  (jump_imm),
        .jump_reg  (jump_reg),
        .imm       (es_imm),
        .jidx      (jidx),
        .fs_pc     (ds_next_pc),
        .rs_value  (src_value[0]),
        .rt_value  (src_value[1]),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    // fetch must not follow a target built from stale operands
    assign br_stall = br_taken && load_stall;

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  id_pkg::word_t     inst,
    output id_pkg::reg_addr_t rs,
    output id_pkg::reg_addr_t rt,
    output id_pkg::reg_addr_t rd,
    output logic [15:0]       imm,
    output logic [25:0]       jidx,
    output id_pkg::alu_op_t   alu_op,
    output logic              src1_is_sa,
    output logic              src1_is_pc,
    output logic              src2_is_imm,
    output logic              src2_is_imm_zero,
    output logic              src2_is_8,
    output logic              load_op,
    output logic              mem_we,
    output logic              gr_we,
    output id_pkg::reg_addr_t dest,
    output logic              uses_rs,
    output logic              uses_rt,
    output logic              br_eq,
    output logic              br_ne,
    output logic              jump_imm,
    output logic              jump_reg
);
    import id_pkg::*;

    logic [5:0] op;
    logic [5:0] func;
    logic [4:0] sa;
    logic       r_arith;
    logic       r_shift;
    logic       inst_addu, inst_subu, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_sll, inst_srl, inst_sra;
    logic       inst_addiu, inst_slti, inst_sltiu;
    logic       inst_andi, inst_ori, inst_xori, inst_lui;
    logic       inst_lw, inst_sw;
    logic       inst_beq, inst_bne, inst_j, inst_jal, inst_jr, inst_jalr;
    logic       dst_is_rt;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];
    assign imm  = inst[15:0];
    assign jidx = inst[25:0];

    // three-register forms need sa == 0, shifts need rs == 0
    assign r_arith = (op == OP_SPECIAL) && (sa == 5'd0);
    assign r_shift = (op == OP_SPECIAL) && (rs == 5'd0);

    assign inst_addu  = r_arith && (func == FN_ADDU);
    assign inst_subu  = r_arith && (func == FN_SUBU);
    assign inst_slt   = r_arith && (func == FN_SLT);
    assign inst_sltu  = r_arith && (func == FN_SLTU);
    assign inst_and   = r_arith && (func == FN_AND);
    assign inst_or    = r_arith && (func == FN_OR);
    assign inst_xor   = r_arith && (func == FN_XOR);
    assign inst_nor   = r_arith && (func == FN_NOR);
    assign inst_sll   = r_shift && (func == FN_SLL);
    assign inst_srl   = r_shift && (func == FN_SRL);
    assign inst_sra   = r_shift && (func == FN_SRA);
    assign inst_jr    = r_arith && (func == FN_JR) && (rt == 5'd0) && (rd == 5'd0);
    assign inst_jalr  = r_arith && (func == FN_JALR) && (rt == 5'd0);
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && (rs == 5'd0);
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign inst_beq   = (op == OP_BEQ);
    assign inst_bne   = (op == OP_BNE);
    assign inst_j     = (op == OP_J);
    assign inst_jal   = (op == OP_JAL);

    always_comb begin
        alu_op = '0;
        // link address pc + 8 also goes through the adder
        alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal | inst_jalr;
        alu_op[ALU_SUB]  = inst_subu;
        alu_op[ALU_SLT]  = inst_slt | inst_slti;
        alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
        alu_op[ALU_AND]  = inst_and | inst_andi;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or | inst_ori;
        alu_op[ALU_XOR]  = inst_xor | inst_xori;
        alu_op[ALU_SLL]  = inst_sll;
        alu_op[ALU_SRL]  = inst_srl;
        alu_op[ALU_SRA]  = inst_sra;
        alu_op[ALU_LUI]  = inst_lui;
    end

    assign src1_is_sa       = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc       = inst_jal | inst_jalr;
    assign src2_is_imm      = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign src2_is_imm_zero = inst_andi | inst_ori | inst_xori;
    assign src2_is_8        = inst_jal | inst_jalr;
    assign load_op          = inst_lw;
    assign mem_we           = inst_sw;

    // sw uses the adder but writes no register
    assign gr_we     = (|alu_op) & ~inst_sw;
    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori |
                       inst_lui | inst_lw;
    assign dest      = inst_jal  ? REG_LINK :
                       dst_is_rt ? rt :
                       gr_we     ? rd : 5'd0;

    assign uses_rs = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or |
                     inst_xor | inst_nor | inst_addiu | inst_slti | inst_sltiu | inst_andi |
                     inst_ori | inst_xori | inst_lw | inst_sw | inst_beq | inst_bne |
                     inst_jr | inst_jalr;
    assign uses_rt = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or |
                     inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | inst_sw |
                     inst_beq | inst_bne;

    assign br_eq    = inst_beq;
    assign br_ne    = inst_bne;
    assign jump_imm = inst_j | inst_jal;
    assign jump_reg = inst_jr | inst_jalr;

endmodule

//--- design/operand_unit.sv
`timescale 1ns/1ps

module operand_unit (
    input  id_pkg::reg_addr_t src,
    input  logic              uses_src,
    input  id_pkg::word_t     rf_data,
    input  id_pkg::reg_addr_t exe_dest,
    input  id_pkg::reg_addr_t mem_dest,
    input  id_pkg::reg_addr_t wb_dest,
    input  id_pkg::word_t     exe_data,
    input  id_pkg::word_t     mem_data,
    input  id_pkg::word_t     wb_data,
    input  logic              es_load_op,
    input  logic              ms_load_op,
    input  logic              data_ok,
    output id_pkg::word_t     value,
    output logic              stall
);

    logic live;
    logic hit_exe;
    logic hit_mem;
    logic hit_wb;

    // r0 and unread sources never depend on anything
    assign live    = uses_src && (src != 5'd0);
    assign hit_exe = live && (src == exe_dest);
    assign hit_mem = live && (src == mem_dest);
    assign hit_wb  = live && (src == wb_dest);

    // youngest stage wins
    assign value = hit_exe ? exe_data :
                   hit_mem ? mem_data :
                   hit_wb  ? wb_data  : rf_data;

    assign stall = (hit_exe && es_load_op) || (hit_mem && ms_load_op && !data_ok);

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                                        clk,
    input  id_pkg::reg_addr_t [id_pkg::NUM_SRC-1:0]     raddr,
    output id_pkg::word_t     [id_pkg::NUM_SRC-1:0]     rdata,
    input  logic                                        we,
    input  id_pkg::reg_addr_t                           waddr,
    input  id_pkg::word_t                               wdata
);
    import id_pkg::*;

    // r0 has no storage
    word_t regs [REG_NUM-1:1];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    for (genvar p = 0; p < NUM_SRC; p++) begin : g_rd
        assign rdata[p] = (raddr[p] == 5'd0) ? '0 : regs[raddr[p]];
    end

endmodule

//--- dv/id_stage_checker.sv
`timescale 1ns/1ps

module id_stage_checker (
    input logic              clk,
    input logic              reset,
    input logic              es_allowin,
    input logic              ds_allowin,
    input logic              ds_to_es_valid,
    input id_pkg::word_t     es_pc,
    input id_pkg::reg_addr_t es_dest,
    input logic              br_taken,
    input logic              br_stall
);

    // stage comes out of reset empty
    a_empty_after_reset: assert property (@(posedge clk) reset |=> !ds_to_es_valid)
        else $error("ds_to_es_valid high in the cycle after reset");

    // held instruction keeps its outputs
    a_hold_outputs: assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |=> ($stable(es_pc) && $stable(es_dest)))
        else $error("es_pc or es_dest changed under back-pressure");

    // a stalled branch keeps its place in the stage
    a_stalled_branch_held: assert property (@(posedge clk) disable iff (reset)
        br_stall |-> (br_taken ##1 $stable(es_pc)))
        else $error("br_stall without br_taken or the stalled branch left the stage");

    a_no_allowin_when_held: assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |-> !ds_allowin)
        else $error("ds_allowin high while the stage is blocked");

endmodule

bind id_stage id_stage_checker u_chk (
    .clk            (clk),
    .reset          (reset),
    .es_allowin     (es_allowin),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .es_pc          (es_pc),
    .es_dest        (es_dest),
    .br_taken       (br_taken),
    .br_stall       (br_stall)
);

//--- dv/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
    import id_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int LIMIT_NS     = (NUM_TESTS * 100 + RESET_CYCLES) * CLK_PERIOD;

    logic      clk = 1'b0;
    logic      reset;
    logic      es_allowin, ds_allowin, fs_to_ds_valid;
    word_t     fs_inst, fs_pc, fs_inst_pc;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;
    reg_addr_t exe_dest, mem_dest, wb_dest;
    word_t     exe_data, mem_data, wb_data;
    logic      es_load_op, ms_load_op, data_ok;
    logic      ds_to_es_valid;
    alu_op_t   es_alu_op;
    logic      es_src1_is_sa, es_src1_is_pc, es_src2_is_imm, es_src2_is_imm_zero;
    logic      es_src2_is_8, es_load_op_out, es_mem_we, es_gr_we;
    reg_addr_t es_dest;
    logic [15:0] es_imm;
    word_t     es_rs_value, es_rt_value, es_pc;
    logic      br_taken, br_stall;
    word_t     br_target;

    word_t rng = 32'd5215;
    word_t reg_val [0:7];

    id_stage dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(LIMIT_NS);
        report_failure("simulation timed out before the tests finished");
    end

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_alu_op(string name, alu_op_t exp, alu_op_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic word_t xorshift(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    logic [4:0] sa, logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic alu_op_t alu_onehot(int pos);
        alu_op_t v;
        v = '0;
        v[pos] = 1'b1;
        return v;
    endfunction

    // drive point 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic sample();
        @(negedge clk);
    endtask

    task automatic clear_hazards();
        exe_dest   = '0;
        mem_dest   = '0;
        wb_dest    = '0;
        es_load_op = 1'b0;
        ms_load_op = 1'b0;
        data_ok    = 1'b1;
        wb_we      = 1'b0;
    endtask

    task automatic offer_inst(word_t inst, word_t pc);
        fs_inst        = inst;
        fs_inst_pc     = pc;
        fs_pc          = pc + 32'd4;
        fs_to_ds_valid = 1'b1;
    endtask

    // returns at the sample point of the cycle the instruction sits in the stage
    task automatic wait_accept();
        sample();
        while (!ds_allowin) begin
            sample();
        end
        next_cycle();
        fs_to_ds_valid = 1'b0;
        sample();
    endtask

    task automatic send_inst(word_t inst, word_t pc);
        next_cycle();
        offer_inst(inst, pc);
        wait_accept();
    endtask

    // flag order is sa, pc, imm, imm_zero, 8, load, mem_we, gr_we
    task automatic expect_ctrl(string tag, alu_op_t alu, logic [7:0] f, reg_addr_t dst);
        check_bit({tag, " ds_to_es_valid"}, 1'b1, ds_to_es_valid);
        check_alu_op({tag, " es_alu_op"}, alu, es_alu_op);
        check_bit({tag, " es_src1_is_sa"}, f[7], es_src1_is_sa);
        check_bit({tag, " es_src1_is_pc"}, f[6], es_src1_is_pc);
        check_bit({tag, " es_src2_is_imm"}, f[5], es_src2_is_imm);
        check_bit({tag, " es_src2_is_imm_zero"}, f[4], es_src2_is_imm_zero);
        check_bit({tag, " es_src2_is_8"}, f[3], es_src2_is_8);
        check_bit({tag, " es_load_op_out"}, f[2], es_load_op_out);
        check_bit({tag, " es_mem_we"}, f[1], es_mem_we);
        check_bit({tag, " es_gr_we"}, f[0], es_gr_we);
        check_addr({tag, " es_dest"}, dst, es_dest);
    endtask

    task automatic test_decode();
        next_cycle();
        clear_hazards();
        es_allowin = 1'b1;
        send_inst(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h0000_0100);
        expect_ctrl("addu", alu_onehot(ALU_ADD), 8'b0000_0001, 5'd3);
        send_inst(enc_i(OP_ADDIU, 5'd1, 5'd4, 16'h8001), 32'h0000_0104);
        expect_ctrl("addiu", alu_onehot(ALU_ADD), 8'b0010_0001, 5'd4);
        check_word("addiu es_imm", 32'h0000_8001, {16'h0000, es_imm});
        send_inst(enc_i(OP_ORI, 5'd1, 5'd5, 16'hf00f), 32'h0000_0108);
        expect_ctrl("ori", alu_onehot(ALU_OR), 8'b0001_0001, 5'd5);
        check_word("ori es_imm", 32'h0000_f00f, {16'h0000, es_imm});
        send_inst(enc_i(OP_LUI, 5'd0, 5'd6, 16'h1234), 32'h0000_010c);
        expect_ctrl("lui", alu_onehot(ALU_LUI), 8'b0010_0001, 5'd6);
        send_inst(enc_r(5'd0, 5'd2, 5'd7, 5'd4, FN_SLL), 32'h0000_0110);
        expect_ctrl("sll", alu_onehot(ALU_SLL), 8'b1000_0001, 5'd7);
        send_inst(enc_i(OP_LW, 5'd1, 5'd8, 16'h0010), 32'h0000_0114);
        expect_ctrl("lw", alu_onehot(ALU_ADD), 8'b0010_0101, 5'd8);
        send_inst(enc_i(OP_SW, 5'd1, 5'd2, 16'h0020), 32'h0000_0118);
        expect_ctrl("sw", alu_onehot(ALU_ADD), 8'b0010_0010, 5'd0);
    endtask

    task automatic test_regfile();
        next_cycle();
        clear_hazards();
        for (int r = 0; r < 8; r++) begin
            rng        = xorshift(rng);
            wb_we      = 1'b1;
            wb_waddr   = reg_addr_t'(r);
            wb_wdata   = rng;
            reg_val[r] = (r == 0) ? '0 : rng;
            next_cycle();
        end
        wb_we = 1'b0;
        send_inst(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h0000_0200);
        check_word("es_rs_value r1", reg_val[1], es_rs_value);
        check_word("es_rt_value r2", reg_val[2], es_rt_value);
        send_inst(enc_r(5'd0, 5'd7, 5'd3, 5'd0, FN_ADDU), 32'h0000_0204);
        check_word("es_rs_value r0", 32'h0, es_rs_value);
        check_word("es_rt_value r7", reg_val[7], es_rt_value);
    endtask

    task automatic test_forwarding();
        next_cycle();
        clear_hazards();
        es_allowin = 1'b0;
        exe_dest   = 5'd5;
        mem_dest   = 5'd5;
        wb_dest    = 5'd5;
        rng        = xorshift(rng);
        exe_data   = rng;
        rng        = xorshift(rng);
        mem_data   = rng;
        rng        = xorshift(rng);
        wb_data    = rng;
        send_inst(enc_r(5'd5, 5'd6, 5'd3, 5'd0, FN_ADDU), 32'h0000_0300);
        check_word("es_rs_value exe", exe_data, es_rs_value);
        check_word("es_rt_value rf", reg_val[6], es_rt_value);
        next_cycle();
        exe_dest = '0;
        sample();
        check_word("es_rs_value mem", mem_data, es_rs_value);
        next_cycle();
        mem_dest = '0;
        sample();
        check_word("es_rs_value wb", wb_data, es_rs_value);
        next_cycle();
        wb_dest = '0;
        sample();
        check_word("es_rs_value rf", reg_val[5], es_rs_value);
        next_cycle();
        es_allowin = 1'b1;
        // every destination is r0 now with nonzero data
        send_inst(enc_r(5'd0, 5'd6, 5'd3, 5'd0, FN_ADDU), 32'h0000_0304);
        check_word("es_rs_value zero source", 32'h0, es_rs_value);
    endtask

    task automatic test_load_stall();
        next_cycle();
        clear_hazards();
        exe_dest   = 5'd5;
        es_load_op = 1'b1;
        rng        = xorshift(rng);
        exe_data   = rng;
        send_inst(enc_r(5'd5, 5'd6, 5'd3, 5'd0, FN_ADDU), 32'h0000_0400);
        for (int i = 0; i < 3; i++) begin
            check_bit("ds_to_es_valid exe stall", 1'b0, ds_to_es_valid);
            check_bit("ds_allowin exe stall", 1'b0, ds_allowin);
            next_cycle();
            sample();
        end
        next_cycle();
        es_load_op = 1'b0;
        sample();
        check_bit("ds_to_es_valid exe release", 1'b1, ds_to_es_valid);
        check_word("es_pc exe release", 32'h0000_0400, es_pc);
        check_word("es_rs_value exe release", exe_data, es_rs_value);
        next_cycle();
        clear_hazards();
        ms_load_op = 1'b1;
        mem_dest   = 5'd6;
        data_ok    = 1'b0;
        rng        = xorshift(rng);
        mem_data   = rng;
        send_inst(enc_r(5'd5, 5'd6, 5'd3, 5'd0, FN_ADDU), 32'h0000_0404);
        for (int i = 0; i < 2; i++) begin
            check_bit("ds_to_es_valid mem stall", 1'b0, ds_to_es_valid);
            check_bit("ds_allowin mem stall", 1'b0, ds_allowin);
            next_cycle();
            sample();
        end
        next_cycle();
        data_ok = 1'b1;
        sample();
        check_bit("ds_to_es_valid mem release", 1'b1, ds_to_es_valid);
        check_word("es_rt_value mem release", mem_data, es_rt_value);
    endtask

    task automatic test_branch();
        word_t pc;
        word_t off;
        word_t exp;
        logic [15:0] imm;
        logic [25:0] idx;
        next_cycle();
        clear_hazards();
        pc  = 32'h0000_1000;
        imm = 16'hfff8;
        send_inst(enc_i(OP_BEQ, 5'd1, 5'd1, imm), pc);
        off = {{16{imm[15]}}, imm};
        exp = pc + 32'd4 + (off << 2);
        check_bit("br_taken beq equal", 1'b1, br_taken);
        check_word("br_target beq", exp, br_target);
        // r1 and r2 hold consecutive xorshift states, which always differ
        send_inst(enc_i(OP_BEQ, 5'd1, 5'd2, imm), pc);
        check_bit("br_taken beq unequal", 1'b0, br_taken);
        pc  = 32'h9000_0040;
        idx = 26'h1234567;
        send_inst({OP_J, idx}, pc);
        exp = {pc[31:28], idx, 2'b00};
        check_bit("br_taken j", 1'b1, br_taken);
        check_word("br_target j", exp, br_target);
        next_cycle();
        exe_dest = 5'd5;
        rng      = xorshift(rng);
        exe_data = rng;
        send_inst(enc_r(5'd5, 5'd0, 5'd0, 5'd0, FN_JR), 32'h0000_2000);
        check_bit("br_taken jr", 1'b1, br_taken);
        check_word("br_target jr", exe_data, br_target);
        next_cycle();
        exe_dest   = 5'd1;
        es_load_op = 1'b1;
        send_inst(enc_i(OP_BEQ, 5'd1, 5'd1, 16'h0004), 32'h0000_3000);
        check_bit("br_stall beq load", 1'b1, br_stall);
        check_bit("ds_to_es_valid beq load", 1'b0, ds_to_es_valid);
        next_cycle();
        es_load_op = 1'b0;
        sample();
        check_bit("br_stall beq release", 1'b0, br_stall);
        check_bit("ds_to_es_valid beq release", 1'b1, ds_to_es_valid);
    endtask

    task automatic test_back_pressure();
        next_cycle();
        clear_hazards();
        es_allowin = 1'b0;
        send_inst(enc_r(5'd1, 5'd2, 5'd9, 5'd0, FN_ADDU), 32'h0000_4000);
        next_cycle();
        offer_inst(enc_i(OP_ORI, 5'd1, 5'd10, 16'h00ff), 32'h0000_4004);
        for (int i = 0; i < 3; i++) begin
            sample();
            check_bit("ds_to_es_valid held", 1'b1, ds_to_es_valid);
            check_bit("ds_allowin held", 1'b0, ds_allowin);
            check_word("es_pc held", 32'h0000_4000, es_pc);
            check_addr("es_dest held", 5'd9, es_dest);
            next_cycle();
        end
        es_allowin = 1'b1;
        wait_accept();
        check_word("es_pc next", 32'h0000_4004, es_pc);
        check_addr("es_dest next", 5'd10, es_dest);
    endtask

    initial begin
        reset          = 1'b1;
        es_allowin     = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_inst        = '0;
        fs_pc          = '0;
        fs_inst_pc     = '0;
        wb_waddr       = '0;
        wb_wdata       = '0;
        exe_data       = '0;
        mem_data       = '0;
        wb_data        = '0;
        clear_hazards();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        sample();
        check_bit("ds_to_es_valid after reset", 1'b0, ds_to_es_valid);
        check_bit("ds_allowin after reset", 1'b1, ds_allowin);
        check_bit("br_taken after reset", 1'b0, br_taken);

        test_decode();
        test_regfile();
        test_forwarding();
        test_load_stall();
        test_branch();
        test_back_pressure();

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- id_stage.f
design/id_pkg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_unit.sv
design/branch_unit.sv
design/id_stage.sv
dv/id_stage_checker.sv
dv/id_stage_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module id_stage_tb -f id_stage.f -o sim_id_stage \
    && ./obj_dir/sim_id_stage \
    || exit 1
